// ==== include/sq_defines.svh ====
// Shared sizes for the pipelined 16-bit squarer
// Digit width times digit count must equal the operand width
// The result width must hold the full square of the operand
// Latency counts the input register, the weight stages and the resolve stage

`ifndef SQ_DEFINES_SVH
`define SQ_DEFINES_SVH

// Operand and digit split
`define SQ_WIDTH 16
`define SQ_DIGIT_W 4
`define SQ_NUM_DIGITS 4

// One pipeline stage per weight index, 2 * digits - 1
`define SQ_NUM_WEIGHTS 7

// Square and carry-save accumulator width
`define SQ_RESULT_W 32

// Edges from operand_valid sample to square_valid
`define SQ_LATENCY 9

`endif

// ==== design/sq_pkg.sv ====
// Types shared by the squarer stages
// The operand is written as a raw word and read back as four digits
// Digit a is the most significant, d the least

`include "sq_defines.svh"

package sq_pkg;

   ////////////////////////////////////////
   // Digit view of the operand
   ////////////////////////////////////////

   typedef struct packed {
      logic [`SQ_DIGIT_W-1:0] a;
      logic [`SQ_DIGIT_W-1:0] b;
      logic [`SQ_DIGIT_W-1:0] c;
      logic [`SQ_DIGIT_W-1:0] d;
   } sq_digits_t;

   ////////////////////////////////////////
   // Operand word, raw or split
   ////////////////////////////////////////

   // Top level fills raw, the stages decode digits
   typedef union packed {
      logic [`SQ_WIDTH-1:0] raw;
      sq_digits_t           digits;
   } sq_operand_u;

endpackage

// ==== design/weight_column_stage.sv ====
// One weight column of the squarer pipeline, one cycle deep
// Adds the digit-pair products whose indices sum to WEIGHT into the
// carry-save accumulator; the words wrap modulo 2**SQ_RESULT_W
// Data registers carry no reset, only the valid bit is cleared

`timescale 1ns/1ps

`include "sq_defines.svh"

module weight_column_stage #(
   parameter int WEIGHT = 0
) (
   input  logic                     Clock,
   input  logic                     arst_n,
   input  logic                     valid,
   input  sq_pkg::sq_operand_u      operand,
   input  logic [`SQ_RESULT_W-1:0]  acc_sum,
   input  logic [`SQ_RESULT_W-1:0]  acc_carry,
   output logic                     next_valid,
   output sq_pkg::sq_operand_u      next_operand,
   output logic [`SQ_RESULT_W-1:0]  next_sum,
   output logic [`SQ_RESULT_W-1:0]  next_carry
);

   import sq_pkg::*;

   // Bit position of this column in the square
   localparam int SHIFT = WEIGHT * `SQ_DIGIT_W;

   sq_digits_t              digits_in;
   logic [`SQ_DIGIT_W-1:0]  digit [`SQ_NUM_DIGITS];
   logic [`SQ_RESULT_W-1:0] term;
   logic [`SQ_RESULT_W-1:0] shifted_term;
   logic [`SQ_RESULT_W-1:0] csa_sum;
   logic [`SQ_RESULT_W-1:0] csa_carry;

   ////////////////////////////////////////
   // Digit decode
   ////////////////////////////////////////

   assign digits_in = operand.digits;

   // Index 0 is the lowest digit
   assign digit[0] = digits_in.d;
   assign digit[1] = digits_in.c;
   assign digit[2] = digits_in.b;
   assign digit[3] = digits_in.a;

   ////////////////////////////////////////
   // Partial products of this weight
   ////////////////////////////////////////

   always_comb
   begin
      term = '0;
      for (int i = 0; i < `SQ_NUM_DIGITS; i++)
      begin
         for (int j = i; j < `SQ_NUM_DIGITS; j++)
         begin
            if (i + j == WEIGHT)
            begin
               // Squares once, cross products twice
               if (i == j)
                  term = term + `SQ_RESULT_W'(digit[i]) * `SQ_RESULT_W'(digit[j]);
               else
                  term = term + ((`SQ_RESULT_W'(digit[i]) * `SQ_RESULT_W'(digit[j])) << 1);
            end
         end
      end
   end

   // Move the term to its column
   assign shifted_term = term << SHIFT;

   ////////////////////////////////////////
   // 3:2 compression
   ////////////////////////////////////////

   assign csa_sum   = shifted_term ^ acc_sum ^ acc_carry;
   assign csa_carry = ((shifted_term & acc_sum)
                     | (shifted_term & acc_carry)
                     | (acc_sum & acc_carry)) << 1;

   ////////////////////////////////////////
   // Stage registers
   ////////////////////////////////////////

   always_ff @(posedge Clock or negedge arst_n)
   begin
      if (!arst_n)
         next_valid <= 1'b0;
      else
         next_valid <= valid;
   end

   // Operand rides along for the later columns
   always_ff @(posedge Clock)
   begin
      next_operand <= operand;
      next_sum     <= csa_sum;
      next_carry   <= csa_carry;
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   a_valid_known: assert property (
      @(posedge Clock) disable iff (!arst_n)
      !$isunknown(next_valid)
   );

   // A known operand upstream must give known accumulator words here
   a_acc_known: assert property (
      @(posedge Clock) disable iff (!arst_n)
      next_valid |-> !$isunknown({next_sum, next_carry})
   );

endmodule

// ==== design/carry_resolve_stage.sv ====
// Last stage of the squarer, one cycle deep
// Resolves the carry-save pair with a plain carry-propagate add
// Carry out of the top bit is dropped, the square always fits

`timescale 1ns/1ps

`include "sq_defines.svh"

module carry_resolve_stage (
   input  logic                     Clock,
   input  logic                     arst_n,
   input  logic                     valid,
   input  logic [`SQ_RESULT_W-1:0]  acc_sum,
   input  logic [`SQ_RESULT_W-1:0]  acc_carry,
   output logic                     square_valid,
   output logic [`SQ_RESULT_W-1:0]  square
);

   logic [`SQ_RESULT_W-1:0] resolved;

   // Carry-propagate add
   assign resolved = acc_sum + acc_carry;

   ////////////////////////////////////////
   // Output register
   ////////////////////////////////////////

   always_ff @(posedge Clock or negedge arst_n)
   begin
      if (!arst_n)
         square_valid <= 1'b0;
      else
         square_valid <= valid;
   end

   always_ff @(posedge Clock)
   begin
      square <= resolved;
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Whole pipeline has to deliver a clean word
   a_square_known: assert property (
      @(posedge Clock) disable iff (!arst_n)
      square_valid |-> !$isunknown(square)
   );

endmodule

// ==== design/squarer_top.sv ====
// Pipelined 16-bit squarer, free-running stream with valid only
// Accepts one operand per cycle, no back-pressure, bubbles pass through
// Result appears SQ_LATENCY edges after the operand is sampled
// Only valid bits are reset, data words start unknown

`timescale 1ns/1ps

`include "sq_defines.svh"

module squarer_top (
   input  logic                     Clock,
   input  logic                     arst_n,
   input  logic                     operand_valid,
   input  logic [`SQ_WIDTH-1:0]     operand,
   output logic                     square_valid,
   output logic [`SQ_RESULT_W-1:0]  square
);

   import sq_pkg::*;

   // Input register
   logic        in_valid;
   sq_operand_u in_operand;

   // Stage boundaries, entry 0 feeds the first column
   logic                    valid_pipe [0:`SQ_NUM_WEIGHTS];
   sq_operand_u             op_pipe    [0:`SQ_NUM_WEIGHTS];
   logic [`SQ_RESULT_W-1:0] sum_pipe   [0:`SQ_NUM_WEIGHTS];
   logic [`SQ_RESULT_W-1:0] carry_pipe [0:`SQ_NUM_WEIGHTS];

   ////////////////////////////////////////
   // Input register
   ////////////////////////////////////////

   always_ff @(posedge Clock or negedge arst_n)
   begin
      if (!arst_n)
         in_valid <= 1'b0;
      else
         in_valid <= operand_valid;
   end

   always_ff @(posedge Clock)
   begin
      in_operand.raw <= operand;
   end

   assign valid_pipe[0] = in_valid;
   assign op_pipe[0]    = in_operand;

   // Accumulator starts empty
   assign sum_pipe[0]   = '0;
   assign carry_pipe[0] = '0;

   ////////////////////////////////////////
   // Weight columns 0 to 6
   ////////////////////////////////////////

   genvar k;
   generate
      for (k = 0; k < `SQ_NUM_WEIGHTS; k++)
      begin : g_weight
         weight_column_stage #(
            .WEIGHT(k)
         ) u_stage (
            .Clock        (Clock),
            .arst_n       (arst_n),
            .valid        (valid_pipe[k]),
            .operand      (op_pipe[k]),
            .acc_sum      (sum_pipe[k]),
            .acc_carry    (carry_pipe[k]),
            .next_valid   (valid_pipe[k+1]),
            .next_operand (op_pipe[k+1]),
            .next_sum     (sum_pipe[k+1]),
            .next_carry   (carry_pipe[k+1])
         );
      end
   endgenerate

   ////////////////////////////////////////
   // Final carry-propagate stage
   ////////////////////////////////////////

   carry_resolve_stage u_resolve (
      .Clock        (Clock),
      .arst_n       (arst_n),
      .valid        (valid_pipe[`SQ_NUM_WEIGHTS]),
      .acc_sum      (sum_pipe[`SQ_NUM_WEIGHTS]),
      .acc_carry    (carry_pipe[`SQ_NUM_WEIGHTS]),
      .square_valid (square_valid),
      .square       (square)
   );

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Unknown bits here would spread through every column
   a_operand_known: assert property (
      @(posedge Clock) disable iff (!arst_n)
      operand_valid |-> !$isunknown(operand)
   );

endmodule

// ==== dv/tb_clock_gen.sv ====
// Clock and reset source for the squarer testbench
// Clock period 100 ns, reset held low for the first 5 rising edges
// Reset is released on a rising edge

`timescale 1ns/1ps

module tb_clock_gen (
   output logic Clock,
   output logic arst_n
);

   localparam int HALF_PERIOD = 50;
   localparam int RESET_CYCLES = 5;

   initial
   begin
      Clock = 1'b0;
      forever #HALF_PERIOD Clock = ~Clock;
   end

   initial
   begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge Clock);
      arst_n <= 1'b1;
   end

endmodule

// ==== dv/tb_squarer.sv ====
// Testbench for the pipelined squarer
// Concurrent assertions compare every result against a delay line of inputs
// Stimulus runs five tests and drains the pipeline after each one
// Random operands come from a fixed-seed LCG

`timescale 1ns/1ps

`include "sq_defines.svh"

module tb_squarer;

   localparam int LAT = `SQ_LATENCY;
   localparam int DRAIN_LIMIT = 4 * `SQ_LATENCY;
   localparam int RESET_LIMIT = 20;

   logic                    Clock;
   logic                    arst_n;
   logic                    operand_valid;
   logic [`SQ_WIDTH-1:0]    operand;
   logic                    square_valid;
   logic [`SQ_RESULT_W-1:0] square;

   // Delay line of the inputs seen by the DUT
   logic                    hist_valid [0:LAT-1];
   logic [`SQ_WIDTH-1:0]    hist_op    [0:LAT-1];

   int          errors;
   int          tests_run;
   int          sent;
   int          received;
   logic [31:0] lcg_state;

   tb_clock_gen u_clock_gen (
      .Clock  (Clock),
      .arst_n (arst_n)
   );

   squarer_top uut (
      .Clock         (Clock),
      .arst_n        (arst_n),
      .operand_valid (operand_valid),
      .operand       (operand),
      .square_valid  (square_valid),
      .square        (square)
   );

   ////////////////////////////////////////
   // Reference helpers
   ////////////////////////////////////////

   function automatic logic [`SQ_RESULT_W-1:0] square_of(input logic [`SQ_WIDTH-1:0] x);
      return `SQ_RESULT_W'(x) * `SQ_RESULT_W'(x);
   endfunction

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   always @(posedge Clock or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < LAT; i++)
            hist_valid[i] <= 1'b0;
      end
      else
      begin
         hist_valid[0] <= operand_valid;
         hist_op[0]    <= operand;
         for (int i = 1; i < LAT; i++)
         begin
            hist_valid[i] <= hist_valid[i-1];
            hist_op[i]    <= hist_op[i-1];
         end
      end
   end

   // Results seen so far
   always @(posedge Clock or negedge arst_n)
   begin
      if (!arst_n)
         received <= 0;
      else if (square_valid)
         received <= received + 1;
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   a_square_match: assert property (
      @(posedge Clock) disable iff (!arst_n)
      hist_valid[LAT-1] |-> (square_valid && square == square_of(hist_op[LAT-1]))
   ) else
   begin
      errors++;
      if ($sampled(square_valid) !== 1'b1)
         $display("** Error at %0t: square_valid expected 1, got %b",
                  $time, $sampled(square_valid));
      else
         $display("** Error at %0t: square expected %h, got %h",
                  $time, square_of($sampled(hist_op[LAT-1])), $sampled(square));
   end

   // No result without an operand LAT edges earlier
   a_no_stray_valid: assert property (
      @(posedge Clock) disable iff (!arst_n)
      square_valid |-> hist_valid[LAT-1]
   ) else
   begin
      errors++;
      $display("** Error at %0t: square_valid expected 0, got 1", $time);
   end

   a_quiet_in_reset: assert property (
      @(posedge Clock)
      !arst_n |-> !square_valid
   ) else
   begin
      errors++;
      $display("** Error at %0t: square_valid expected 0 in reset, got %b",
               $time, $sampled(square_valid));
   end

   ////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////

   task automatic drive_operand(input logic [`SQ_WIDTH-1:0] value);
      @(posedge Clock);
      operand_valid <= 1'b1;
      operand       <= value;
      sent++;
   endtask

   task automatic drive_idle();
      @(posedge Clock);
      operand_valid <= 1'b0;
   endtask

   task automatic drain_pipeline(input string name);
      int waited;
      drive_idle();
      waited = 0;
      while (received != sent && waited < DRAIN_LIMIT)
      begin
         @(posedge Clock);
         waited++;
      end
      if (received != sent)
      begin
         errors++;
         $display("[%0t] %s: timed out with %0d of %0d results back",
                  $time, name, received, sent);
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      $display("[%0t] test %s finished, %0d errors", $time, name, errors - errors_before);
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial
   begin
      int mark;
      int waited;
      operand_valid = 1'b0;
      operand       = '0;
      errors        = 0;
      tests_run     = 0;
      sent          = 0;
      lcg_state     = 32'h3c5e052a;

      waited = 0;
      while (arst_n !== 1'b1 && waited < RESET_LIMIT)
      begin
         @(posedge Clock);
         waited++;
      end
      if (arst_n !== 1'b1)
      begin
         errors++;
         $display("[%0t] reset was never released", $time);
      end

      // One operand out of reset shows the full latency
      mark = errors;
      drive_idle();
      drive_operand(16'h1234);
      drain_pipeline("reset_quiet");
      finish_test("reset_quiet", mark);

      mark = errors;
      drive_operand(16'h0000);
      drive_operand(16'h0001);
      drive_operand(16'hFFFF);
      drive_operand(16'h8000);
      drive_operand(16'h00FF);
      drain_pipeline("corners");
      finish_test("corners", mark);

      // Single digits, then digit pairs
      mark = errors;
      for (int p = 0; p < `SQ_NUM_DIGITS; p++)
      begin
         for (int v = 1; v < 16; v++)
            drive_operand(`SQ_WIDTH'(v << (p * `SQ_DIGIT_W)));
      end
      for (int p = 0; p < `SQ_NUM_DIGITS; p++)
      begin
         for (int q = p + 1; q < `SQ_NUM_DIGITS; q++)
         begin
            drive_operand(`SQ_WIDTH'((1 << (p * 4)) | (1 << (q * 4))));
            drive_operand(`SQ_WIDTH'((15 << (p * 4)) | (15 << (q * 4))));
            drive_operand(`SQ_WIDTH'((7 << (p * 4)) | (9 << (q * 4))));
         end
      end
      drain_pipeline("weights");
      finish_test("weights", mark);

      mark = errors;
      for (int n = 0; n < 64; n++)
      begin
         lcg_state = lcg_next(lcg_state);
         drive_operand(lcg_state[31:16]);
      end
      drain_pipeline("stream");
      finish_test("stream", mark);

      // Roughly three operands in four cycles
      mark = errors;
      for (int n = 0; n < 80; n++)
      begin
         lcg_state = lcg_next(lcg_state);
         if (lcg_state[30:29] != 2'b00)
            drive_operand(lcg_state[31:16]);
         else
            drive_idle();
      end
      drain_pipeline("bubbles");
      finish_test("bubbles", mark);

      $display("tests %0d, errors %0d", tests_run, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+include
design/sq_pkg.sv
design/weight_column_stage.sv
design/carry_resolve_stage.sv
design/squarer_top.sv
dv/tb_clock_gen.sv
dv/tb_squarer.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      = tb_squarer
FILELIST = build.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^=== PASS ===$$"

clean:
	rm -rf $(OBJ_DIR)
